//--- source/vga_display_pkg.sv
// display package with screen geometry and pixel types for the three-camera compositor
package vga_display_pkg;

  // camera image, QQVGA
  localparam int IMG_COLS    = 160;
  localparam int IMG_ROWS    = 120;
  localparam int NB_IMG_PXLS = 15;   // 160*120 = 19200 < 2**15

  // extras drawn around each image
  localparam int PROX_BAR_W     = 8;   // bar right of the image
  localparam int CENTROID_ROWS  = 8;   // strip below the image
  localparam int CENTROID_BIN_W = 20;  // 8 bins over 160 columns

  // screen position from the VGA sync generator
  typedef logic [9:0] col_t;
  typedef logic [9:0] row_t;

  typedef logic [NB_IMG_PXLS-1:0] frame_addr_t;

  // one VGA colour channel
  typedef logic [3:0] channel_t;

  // frame-buffer word, red in the top nibble
  typedef struct packed {
    channel_t red;
    channel_t green;
    channel_t blue;
  } buf_pixel_t;

  // filter colour, bit 2 red, bit 1 green, bit 0 blue
  typedef logic [2:0] filter_t;

  // one bit per centroid bin, bit 0 is the leftmost bin
  typedef logic [7:0] centroid_t;

  // 7 is nearest, bar reaches the top of the image
  typedef logic [2:0] proximity_t;

endpackage

//--- source/cam_lane.sv
// camera lane that decodes one window, counts its frame address and paints its pixel
`timescale 1ns/1ps

module cam_lane #(
  parameter int col_min = 0  // first screen column of this camera
) (
  input  logic                         rst,        // pixel clock
  input  logic                         clk,        // async reset, active high
  input  logic                         new_pxl,
  input  logic                         rgbmode,    // 1 colour, 0 grayscale
  input  vga_display_pkg::col_t        col,
  input  vga_display_pkg::row_t        row,
  input  vga_display_pkg::buf_pixel_t  frame_pixel,
  input  vga_display_pkg::filter_t     rgbfilter,
  input  vga_display_pkg::centroid_t   centroid,
  input  vga_display_pkg::proximity_t  proximity,
  output vga_display_pkg::frame_addr_t frame_addr,
  output logic                         lane_hit,
  output vga_display_pkg::channel_t    lane_red,
  output vga_display_pkg::channel_t    lane_green,
  output vga_display_pkg::channel_t    lane_blue
);

  import vga_display_pkg::*;

  // image plus proximity bar, one past the last column
  localparam int WIN_END = col_min + IMG_COLS + PROX_BAR_W;

  col_t       rel_col;      // column inside the window
  logic       in_win;
  logic       img_col;
  logic       bar_col;
  logic       img_row;
  logic       cen_row;
  proximity_t prox_thr;
  logic       bar_lit;
  logic       bin_lit;
  channel_t   filt_red;
  channel_t   filt_green;
  channel_t   filt_blue;

  // window decode
  assign in_win  = (col >= col_t'(col_min)) && (col < col_t'(WIN_END));
  assign rel_col = col - col_t'(col_min);
  assign img_col = in_win && (rel_col < col_t'(IMG_COLS));
  assign bar_col = in_win && (rel_col >= col_t'(IMG_COLS));

  assign img_row = row < row_t'(IMG_ROWS);
  assign cen_row = (row >= row_t'(IMG_ROWS)) && (row < row_t'(IMG_ROWS + CENTROID_ROWS));

  // bar grows upwards with proximity, row[6:4] splits 128 rows in 8 steps
  assign prox_thr = 3'd7 - proximity;
  assign bar_lit  = row[6:4] >= prox_thr;

  // each filter bit drives a full channel
  assign filt_red   = {4{rgbfilter[2]}};
  assign filt_green = {4{rgbfilter[1]}};
  assign filt_blue  = {4{rgbfilter[0]}};

  // centroid bin under the current column
  always_comb begin
    bin_lit = 1'b0;
    for (int i = 0; i < $bits(centroid_t); i++) begin
      if ((rel_col >= col_t'(i * CENTROID_BIN_W)) &&
          (rel_col < col_t'((i + 1) * CENTROID_BIN_W))) begin
        bin_lit = centroid[i];
      end
    end
  end

  // lane painter
  always_comb begin
    lane_hit   = in_win;
    lane_red   = '0;  // black by default
    lane_green = '0;
    lane_blue  = '0;
    if (img_row && img_col) begin
      if (rgbmode) begin
        lane_red   = frame_pixel.red;
        lane_green = frame_pixel.green;
        lane_blue  = frame_pixel.blue;
      end else begin
        // green field carries most of the luma
        lane_red   = frame_pixel.green;
        lane_green = frame_pixel.green;
        lane_blue  = frame_pixel.green;
      end
    end else if (img_row && bar_col) begin
      if (bar_lit) begin
        lane_red   = filt_red;
        lane_green = filt_green;
        lane_blue  = filt_blue;
      end
    end else if (cen_row && img_col) begin
      if (bin_lit) begin
        lane_red   = filt_red;
        lane_green = filt_green;
        lane_blue  = filt_blue;
      end
    end
  end

  // frame-buffer read address, follows the image pixels in raster order
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      frame_addr <= '0;
    end else if (!img_row) begin
      frame_addr <= '0;  // rewind once the image rows are done
    end else if (img_col && new_pxl) begin
      frame_addr <= frame_addr + 1'b1;
    end
  end

endmodule

//--- source/vga_pixel_out.sv
// output stage that blanks, merges the three lanes and registers colour with the syncs
`timescale 1ns/1ps

module vga_pixel_out (
  input  logic                      rst,      // pixel clock
  input  logic                      clk,      // async reset, active high
  input  logic                      visible,
  input  logic                      hsync,
  input  logic                      vsync,
  input  logic                      hit_l,
  input  logic                      hit_c,
  input  logic                      hit_r,
  input  vga_display_pkg::channel_t red_l,
  input  vga_display_pkg::channel_t green_l,
  input  vga_display_pkg::channel_t blue_l,
  input  vga_display_pkg::channel_t red_c,
  input  vga_display_pkg::channel_t green_c,
  input  vga_display_pkg::channel_t blue_c,
  input  vga_display_pkg::channel_t red_r,
  input  vga_display_pkg::channel_t green_r,
  input  vga_display_pkg::channel_t blue_r,
  output vga_display_pkg::channel_t vga_red,
  output vga_display_pkg::channel_t vga_green,
  output vga_display_pkg::channel_t vga_blue,
  output logic                      vga_hsync,
  output logic                      vga_vsync
);

  import vga_display_pkg::*;

  channel_t sel_red;
  channel_t sel_green;
  channel_t sel_blue;

  // lane windows are disjoint, at most one hit
  always_comb begin
    sel_red   = '0;
    sel_green = '0;
    sel_blue  = '0;
    if (visible) begin
      if (hit_l) begin
        sel_red   = red_l;
        sel_green = green_l;
        sel_blue  = blue_l;
      end else if (hit_c) begin
        sel_red   = red_c;
        sel_green = green_c;
        sel_blue  = blue_c;
      end else if (hit_r) begin
        sel_red   = red_r;
        sel_green = green_r;
        sel_blue  = blue_r;
      end
    end
  end

  // syncs take the same register stage as the colour
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      vga_red   <= '0;
      vga_green <= '0;
      vga_blue  <= '0;
      vga_hsync <= 1'b0;
      vga_vsync <= 1'b0;
    end else begin
      vga_red   <= sel_red;
      vga_green <= sel_green;
      vga_blue  <= sel_blue;
      vga_hsync <= hsync;
      vga_vsync <= vsync;
    end
  end

endmodule

//--- source/vga_display.sv
// display top that shows three camera frame buffers side by side on VGA
`timescale 1ns/1ps

module vga_display #(
  parameter int col_cam_cen  = 192,  // first column of the centre camera
  parameter int col_cam_rght = 384   // first column of the right camera
) (
  input  logic                         rst,      // pixel clock
  input  logic                         clk,      // async reset, active high
  input  logic                         visible,
  input  logic                         new_pxl,
  input  logic                         hsync,
  input  logic                         vsync,
  input  logic                         rgbmode,
  input  vga_display_pkg::col_t        col,
  input  vga_display_pkg::row_t        row,
  // left camera
  input  vga_display_pkg::filter_t     rgbfilter_l,
  input  vga_display_pkg::centroid_t   centroid_l,
  input  vga_display_pkg::proximity_t  proximity_l,
  input  vga_display_pkg::buf_pixel_t  frame_pixel_l,
  output vga_display_pkg::frame_addr_t frame_addr_l,
  // centre camera
  input  vga_display_pkg::filter_t     rgbfilter_c,
  input  vga_display_pkg::centroid_t   centroid_c,
  input  vga_display_pkg::proximity_t  proximity_c,
  input  vga_display_pkg::buf_pixel_t  frame_pixel_c,
  output vga_display_pkg::frame_addr_t frame_addr_c,
  // right camera
  input  vga_display_pkg::filter_t     rgbfilter_r,
  input  vga_display_pkg::centroid_t   centroid_r,
  input  vga_display_pkg::proximity_t  proximity_r,
  input  vga_display_pkg::buf_pixel_t  frame_pixel_r,
  output vga_display_pkg::frame_addr_t frame_addr_r,
  // VGA pins
  output vga_display_pkg::channel_t    vga_red,
  output vga_display_pkg::channel_t    vga_green,
  output vga_display_pkg::channel_t    vga_blue,
  output logic                         vga_hsync,
  output logic                         vga_vsync
);

  import vga_display_pkg::*;

  logic     hit_l, hit_c, hit_r;
  channel_t red_l, green_l, blue_l;
  channel_t red_c, green_c, blue_c;
  channel_t red_r, green_r, blue_r;

  cam_lane #(.col_min(0)) u_lane_l (
    .rst         (rst),
    .clk         (clk),
    .new_pxl     (new_pxl),
    .rgbmode     (rgbmode),
    .col         (col),
    .row         (row),
    .frame_pixel (frame_pixel_l),
    .rgbfilter   (rgbfilter_l),
    .centroid    (centroid_l),
    .proximity   (proximity_l),
    .frame_addr  (frame_addr_l),
    .lane_hit    (hit_l),
    .lane_red    (red_l),
    .lane_green  (green_l),
    .lane_blue   (blue_l)
  );

  cam_lane #(.col_min(col_cam_cen)) u_lane_c (
    .rst         (rst),
    .clk         (clk),
    .new_pxl     (new_pxl),
    .rgbmode     (rgbmode),
    .col         (col),
    .row         (row),
    .frame_pixel (frame_pixel_c),
    .rgbfilter   (rgbfilter_c),
    .centroid    (centroid_c),
    .proximity   (proximity_c),
    .frame_addr  (frame_addr_c),
    .lane_hit    (hit_c),
    .lane_red    (red_c),
    .lane_green  (green_c),
    .lane_blue   (blue_c)
  );

  cam_lane #(.col_min(col_cam_rght)) u_lane_r (
    .rst         (rst),
    .clk         (clk),
    .new_pxl     (new_pxl),
    .rgbmode     (rgbmode),
    .col         (col),
    .row         (row),
    .frame_pixel (frame_pixel_r),
    .rgbfilter   (rgbfilter_r),
    .centroid    (centroid_r),
    .proximity   (proximity_r),
    .frame_addr  (frame_addr_r),
    .lane_hit    (hit_r),
    .lane_red    (red_r),
    .lane_green  (green_r),
    .lane_blue   (blue_r)
  );

  // one register stage to the pins
  vga_pixel_out u_pixel_out (
    .rst       (rst),
    .clk       (clk),
    .visible   (visible),
    .hsync     (hsync),
    .vsync     (vsync),
    .hit_l     (hit_l),
    .hit_c     (hit_c),
    .hit_r     (hit_r),
    .red_l     (red_l),
    .green_l   (green_l),
    .blue_l    (blue_l),
    .red_c     (red_c),
    .green_c   (green_c),
    .blue_c    (blue_c),
    .red_r     (red_r),
    .green_r   (green_r),
    .blue_r    (blue_r),
    .vga_red   (vga_red),
    .vga_green (vga_green),
    .vga_blue  (vga_blue),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

endmodule

//--- verif/vga_display_checks.svh
// typed compare tasks and pass/fail counters for the VGA display testbench
`ifndef VGA_DISPLAY_CHECKS_SVH
`define VGA_DISPLAY_CHECKS_SVH

  int n_pass = 0;
  int n_fail = 0;

  // colour of one output pixel
  task automatic check_rgb(input string name, input channel_t exp_r, exp_g, exp_b,
                           input channel_t act_r, act_g, act_b);
    if (exp_r === act_r && exp_g === act_g && exp_b === act_b) begin
      n_pass++;
      $display("[PASS] %s rgb %h %h %h", name, act_r, act_g, act_b);
    end else begin
      n_fail++;
      $display("[FAIL] %s expected rgb %h %h %h actual %h %h %h",
               name, exp_r, exp_g, exp_b, act_r, act_g, act_b);
    end
  endtask

  task automatic check_addr(input string name, input frame_addr_t exp_a, act_a);
    if (exp_a === act_a) begin
      n_pass++;
      $display("[PASS] %s addr %0d", name, act_a);
    end else begin
      n_fail++;
      $display("[FAIL] %s expected addr %0d actual %0d", name, exp_a, act_a);
    end
  endtask

  task automatic check_sync(input string name, input logic exp_s, act_s);
    if (exp_s === act_s) begin
      n_pass++;
      $display("[PASS] %s sync %b", name, act_s);
    end else begin
      n_fail++;
      $display("[FAIL] %s expected sync %b actual %b", name, exp_s, act_s);
    end
  endtask

`endif

//--- verif/vga_display_tb.sv
// testbench for the three-camera VGA compositor, replays pixel vectors and sweeps the addresses
`timescale 1ns/1ps

module vga_display_tb;

  import vga_display_pkg::*;

  localparam int N_VEC     = 24;           // vectors in the data file
  localparam int SWEEP_CYC = 3 * 600 + 2;  // three rows then the clear
  localparam int LIMIT     = 2 * N_VEC + SWEEP_CYC + 100;
  localparam int BASE [3]  = '{0, 192, 384};

  logic        rst = 1'b0;  // pixel clock
  logic        clk;         // reset, active high
  logic        visible, new_pxl, hsync, vsync, rgbmode;
  col_t        col;
  row_t        row;
  filter_t     rgbfilter_l, rgbfilter_c, rgbfilter_r;
  centroid_t   centroid_l, centroid_c, centroid_r;
  proximity_t  proximity_l, proximity_c, proximity_r;
  buf_pixel_t  frame_pixel_l, frame_pixel_c, frame_pixel_r;
  frame_addr_t frame_addr_l, frame_addr_c, frame_addr_r;
  channel_t    vga_red, vga_green, vga_blue;
  logic        vga_hsync, vga_vsync;
  logic [31:0] rnd;
  int          cycles = 0;

  `include "vga_display_checks.svh"

  vga_display #(.col_cam_cen(BASE[1]), .col_cam_rght(BASE[2])) u_dut (.*);

  always #20 rst = ~rst;

  // watchdog on the pixel clock
  always @(posedge rst) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_idle(input string tag);
    check_rgb({tag, "_rgb"}, '0, '0, '0, vga_red, vga_green, vga_blue);
    check_sync({tag, "_hsync"}, 1'b0, vga_hsync);
    check_sync({tag, "_vsync"}, 1'b0, vga_vsync);
    check_addr({tag, "_addr_l"}, '0, frame_addr_l);
    check_addr({tag, "_addr_c"}, '0, frame_addr_c);
    check_addr({tag, "_addr_r"}, '0, frame_addr_r);
  endtask

  task automatic check_pixel(input string name, input logic [11:0] rgb, input logic [1:0] sync);
    check_rgb(name, rgb[11:8], rgb[7:4], rgb[3:0], vga_red, vga_green, vga_blue);
    check_sync({name, "_hsync"}, sync[0], vga_hsync);
    check_sync({name, "_vsync"}, sync[1], vga_vsync);
  endtask

  // one vector per clock, its result shows on the next one
  task automatic replay_vectors();
    int          fd, nf, idx, c_in, r_in;
    string       line, vname, pname;
    logic        v_in, m_in;
    logic [11:0] fp [3];
    logic [2:0]  fl [3];
    logic [7:0]  cn [3];
    logic [2:0]  px [3];
    channel_t    er, eg, eb;
    logic [11:0] prev_rgb;
    logic [1:0]  prev_sync;
    fd = $fopen("verif/vga_display_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vectors file");
      n_fail++;
      return;
    end
    idx = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;  // blank or column notes
      end
      nf = $sscanf(line, "%s %h %h %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   vname, v_in, m_in, c_in, r_in, fp[0], fl[0], cn[0], px[0],
                   fp[1], fl[1], cn[1], px[1], fp[2], fl[2], cn[2], px[2], er, eg, eb);
      if (nf != 20) begin
        $display("vector line after vector %0d has %0d fields instead of 20", idx, nf);
        n_fail++;
        continue;
      end
      @(posedge rst);
      visible       <= v_in;
      rgbmode       <= m_in;
      col           <= col_t'(c_in);
      row           <= row_t'(r_in);
      hsync         <= idx[0];  // sync pattern walks with the vector index
      vsync         <= idx[1];
      frame_pixel_l <= fp[0];
      rgbfilter_l   <= fl[0];
      centroid_l    <= cn[0];
      proximity_l   <= px[0];
      frame_pixel_c <= fp[1];
      rgbfilter_c   <= fl[1];
      centroid_c    <= cn[1];
      proximity_c   <= px[1];
      frame_pixel_r <= fp[2];
      rgbfilter_r   <= fl[2];
      centroid_r    <= cn[2];
      proximity_r   <= px[2];
      @(negedge rst);
      if (idx > 0) begin
        check_pixel(pname, prev_rgb, prev_sync);
      end
      pname     = vname;
      prev_rgb  = {er, eg, eb};
      prev_sync = idx[1:0];
      idx++;
    end
    $fclose(fd);
    @(posedge rst);
    @(negedge rst);
    if (idx > 0) begin
      check_pixel(pname, prev_rgb, prev_sync);
    end
    if (idx != N_VEC) begin
      $display("read %0d vectors but %0d were expected", idx, N_VEC);
      n_fail++;
    end
  endtask

  // raster sweep over three image rows, then one row past the image
  task automatic sweep_addresses();
    int model [3];
    model = '{0, 0, 0};
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 600; c++) begin
        @(posedge rst);
        col           <= col_t'(c);
        row           <= row_t'(r);
        new_pxl       <= 1'b1;
        rnd            = $urandom;
        frame_pixel_l <= rnd[11:0];  // buffer contents do not matter here
        frame_pixel_c <= rnd[23:12];
        frame_pixel_r <= {rnd[31:24], rnd[3:0]};
        for (int i = 0; i < 3; i++) begin
          if (c >= BASE[i] && c < BASE[i] + IMG_COLS) begin
            model[i]++;
          end
        end
      end
      @(negedge rst);
      check_addr($sformatf("sweep_row%0d_l", r), frame_addr_t'(model[0]), frame_addr_l);
      check_addr($sformatf("sweep_row%0d_c", r), frame_addr_t'(model[1]), frame_addr_c);
      check_addr($sformatf("sweep_row%0d_r", r), frame_addr_t'(model[2]), frame_addr_r);
    end
    @(posedge rst);
    row <= row_t'(IMG_ROWS);
    col <= '0;
    @(posedge rst);
    @(negedge rst);
    check_addr("clear_l", '0, frame_addr_l);
    check_addr("clear_c", '0, frame_addr_c);
    check_addr("clear_r", '0, frame_addr_r);
  endtask

  initial begin
    rnd            = $urandom(78212);  // seeds the generator for the run
    clk           <= 1'b1;
    visible       <= 1'b1;  // live pixel inputs that reset has to mask
    new_pxl       <= 1'b1;
    hsync         <= 1'b1;
    vsync         <= 1'b1;
    rgbmode       <= 1'b1;
    col           <= '0;
    row           <= '0;
    rgbfilter_l   <= '0;
    rgbfilter_c   <= '0;
    rgbfilter_r   <= '0;
    centroid_l    <= '0;
    centroid_c    <= '0;
    centroid_r    <= '0;
    proximity_l   <= '0;
    proximity_c   <= '0;
    proximity_r   <= '0;
    frame_pixel_l <= '1;
    frame_pixel_c <= '1;
    frame_pixel_r <= '1;
    @(posedge rst);
    @(negedge rst);
    check_idle("reset_hold");
    @(posedge rst);
    clk     <= 1'b0;  // release after two edges
    visible <= 1'b0;
    new_pxl <= 1'b0;
    hsync   <= 1'b0;
    vsync   <= 1'b0;
    @(negedge rst);
    check_idle("reset_exit");
    replay_vectors();
    sweep_addresses();
    $display("%0d checks, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verif/vga_display_vectors.txt
# name visible rgbmode col row, then per camera l c r: frame_pixel rgbfilter centroid proximity
# last three are expected red green blue; col and row decimal, all other fields hex
img_rgb_l       1 1  10   5 a5c 0 00 0 fff 7 ff 7 fff 7 ff 7 a 5 c
img_gray_l      1 0  10   5 a5c 0 00 0 fff 7 ff 7 fff 7 ff 7 5 5 5
img_rgb_c       1 1 351 119 fff 7 ff 7 3e7 0 00 0 fff 7 ff 7 3 e 7
img_gray_r      1 0 384   0 fff 7 ff 7 fff 7 ff 7 9b1 0 00 0 b b b
img_blank_l     0 1  10   5 a5c 0 00 0 fff 7 ff 7 fff 7 ff 7 0 0 0
img_rgb_r       1 1 543  60 000 0 00 0 000 0 00 0 123 0 00 0 1 2 3
prox7_top_l     1 1 160   0 000 5 00 7 000 0 00 0 000 0 00 0 f 0 f
prox0_bot_l     1 1 167 119 000 7 00 0 000 0 00 0 000 0 00 0 f f f
prox0_mid_l     1 1 163 111 000 7 00 0 000 0 00 0 000 0 00 0 0 0 0
prox3_off_c     1 1 352  63 000 0 00 0 000 2 00 3 000 0 00 0 0 0 0
prox3_on_c      1 1 359  64 000 0 00 0 000 2 00 3 000 0 00 0 0 f 0
prox5_on_r      1 1 544  32 000 0 00 0 000 0 00 0 000 4 00 5 f 0 0
prox6_off_r     1 1 551  15 000 0 00 0 000 0 00 0 000 4 00 6 0 0 0
gap_lc          1 1 170  10 fff 7 ff 7 fff 7 ff 7 fff 7 ff 7 0 0 0
gap_cr          1 1 370  64 fff 7 ff 7 fff 7 ff 7 fff 7 ff 7 0 0 0
win_black_l     1 1 165 122 fff 7 ff 7 000 0 00 0 000 0 00 0 0 0 0
cen_bin0_l      1 1   0 120 000 6 01 0 000 0 00 0 000 0 00 0 f f 0
cen_bin1_off_l  1 1  20 120 000 6 01 0 000 0 00 0 000 0 00 0 0 0 0
cen_bin7_c      1 1 351 127 000 0 00 0 000 3 80 0 000 0 00 0 0 f f
cen_bin3_r      1 1 463 124 000 0 00 0 000 0 00 0 000 1 08 0 0 0 f
cen_rnd_on_r    1 1 484 125 000 0 00 0 000 0 00 0 000 7 b6 0 f f f
cen_rnd_off_r   1 1 444 125 000 0 00 0 000 0 00 0 000 7 b6 0 0 0 0
cen_rnd_on_c    1 1 331 121 000 0 00 0 000 1 5a 0 000 0 00 0 0 0 f
cen_past_l      1 1  30 128 fff 7 ff 7 000 0 00 0 000 0 00 0 0 0 0

//--- files.f
+incdir+verif
source/vga_display_pkg.sv
source/cam_lane.sv
source/vga_pixel_out.sv
source/vga_display.sv
verif/vga_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run the VGA display testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module vga_display_tb -o sim_vga_display
out=$(./obj_dir/sim_vga_display)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1
